// File: Makefile
TOP       ?= car_ctl_tb
SEED      ?= 32'hd9d9cb42
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f "-GSEED=$(SEED)"

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
verilog/car_pkg.sv
verilog/key_decoder.sv
verilog/axis_speed.sv
verilog/track_surface_map.sv
verilog/position_tracker.sv
verilog/car_ctl.sv
tests/car_ctl_tb.sv

// File: tests/car_ctl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module car_ctl_tb #(
    parameter logic [31:0] SEED = 32'hd9d9_cb42
);
    import car_pkg::*;

    localparam int D_MIN = 6;
    localparam int D_STEP = 2;
    localparam int D_SLOWED = 14;
    localparam int D_MAX = 16;
    localparam int CLK_PERIOD = 8;
    // Cycle budget of each test in run order.
    localparam int BUDGET_CYCLES = 300 + 400 + 600 + 900 + 7000 + 900;
    localparam int MARGIN_NS = 2000;

    logic             pclk;
    logic             rst;
    logic [3:0]       key;
    logic [POS_W-1:0] xpos;
    logic [POS_W-1:0] ypos;
    logic [1:0]       move_dir;

    int     m_x;
    int     m_y;
    int     m_dir;
    int     m_prev;
    int     x_timer;
    int     x_delay;
    int     y_timer;
    int     y_delay;
    int     cyc;
    int     checks;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;
    integer seed;

    car_ctl #(
        .DELAY_MIN    (D_MIN),
        .DELAY_STEP   (D_STEP),
        .DELAY_SLOWED (D_SLOWED),
        .DELAY_MAX    (D_MAX),
        .DELAY_W      (8)
    ) car_ctl_inst (
        .pclk     (pclk),
        .rst      (rst),
        .key      (key),
        .xpos     (xpos),
        .ypos     (ypos),
        .move_dir (move_dir)
    );

    always #(CLK_PERIOD / 2) pclk = ~pclk;

    function automatic bit on_track_at(input int x, input int y);
        bit hit;
        hit = 1'b0;
        for (int i = 0; i < TRACK_N; i++)
        begin
            if ((x + HIT_HI >= TRACK_X0[i]) && (y + HIT_HI >= TRACK_Y0[i]) &&
                (x + HIT_LO <= TRACK_X1[i]) && (y + HIT_LO <= TRACK_Y1[i]))
                hit = 1'b1;
        end
        return hit;
    endfunction

    // A step is dropped if it would leave the screen or push the hitbox past a wall.
    function automatic int stepped_pos(input int pos, input bit dec, input bit inc,
                                       input int lo, input int hi);
        if (dec && (pos - 1 >= 0) && (pos - 1 + HIT_LO >= lo))
            return pos - 1;
        if (inc && (pos + 1 + HIT_HI <= hi))
            return pos + 1;
        return pos;
    endfunction

    task automatic ramp_axis(inout int timer, inout int delay, input bit held,
                             input bit track, output bit step);
        int target;
        target = track ? D_MIN : D_SLOWED;
        step = 1'b0;
        if (timer < delay)
            timer = timer + 1;
        else
        begin
            timer = 0;
            step = (delay < D_MAX);
            if (held && (delay > target))
                delay = delay - D_STEP;
            else if (held && (delay < target))
                delay = delay + D_STEP;
            else if (!held && (delay < D_MAX))
                delay = delay + D_STEP;
        end
    endtask

    // One clock edge of the reference model.
    task automatic model_update();
        bit valid;
        bit xh;
        bit yh;
        bit xd;
        bit xi;
        bit yd;
        bit yi;
        bit trk;
        bit xs;
        bit ys;
        int kdir;
        if (rst)
        begin
            m_x = 300;
            m_y = 70;
            m_dir = DIR_RIGHT;
            m_prev = DIR_RIGHT;
            x_timer = 0;
            y_timer = 0;
            x_delay = D_MAX;
            y_delay = D_MAX;
            return;
        end
        valid = (key == KEY_UP) || (key == KEY_DOWN) || (key == KEY_LEFT) || (key == KEY_RIGHT);
        kdir = (key == KEY_UP) ? DIR_UP : (key == KEY_DOWN) ? DIR_DOWN :
               (key == KEY_LEFT) ? DIR_LEFT : DIR_RIGHT;
        xh = (key == KEY_LEFT) || (key == KEY_RIGHT);
        yh = (key == KEY_UP) || (key == KEY_DOWN);
        xd = (m_dir == DIR_LEFT) || ((m_prev == DIR_LEFT) && (m_dir != DIR_RIGHT));
        xi = !xd && ((m_dir == DIR_RIGHT) || ((m_prev == DIR_RIGHT) && (m_dir != DIR_LEFT)));
        yd = (m_dir == DIR_UP) || ((m_prev == DIR_UP) && (m_dir != DIR_DOWN));
        yi = !yd && ((m_dir == DIR_DOWN) || ((m_prev == DIR_DOWN) && (m_dir != DIR_UP)));
        trk = on_track_at(m_x, m_y);
        ramp_axis(x_timer, x_delay, xh, trk, xs);
        ramp_axis(y_timer, y_delay, yh, trk, ys);
        if (xs)
            m_x = stepped_pos(m_x, xd, xi, WALL_X_LO, WALL_X_HI);
        if (ys)
            m_y = stepped_pos(m_y, yd, yi, WALL_Y_LO, WALL_Y_HI);
        if (valid && (kdir != m_dir))
        begin
            m_prev = m_dir;
            m_dir = kdir;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h (cycle %0d)", name, got, exp, cyc);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        test_errors++;
        $display("Failure at cycle %0d: %s", cyc, what);
    endtask

    // Outputs are compared 1 ns after the edge; callers drive keys right after.
    task automatic advance_cycle();
        @(posedge pclk);
        model_update();
        cyc++;
        #1;
        check_value("move_dir", move_dir, m_dir);
        check_value("xpos", xpos, m_x);
        check_value("ypos", ypos, m_y);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        key = 4'b0000;
        repeat (2) advance_cycle();
        rst = 1'b0;
    endtask

    // Gap in cycles until the axis moves, or -1 if it stays put for limit cycles.
    task automatic wait_pos_change(input bit y_axis, input int limit, output int gap);
        int  start;
        bit  seen;
        start = y_axis ? int'(ypos) : int'(xpos);
        gap = 0;
        seen = 1'b0;
        while (!seen && (gap < limit))
        begin
            advance_cycle();
            gap++;
            seen = ((y_axis ? int'(ypos) : int'(xpos)) != start);
        end
        if (!seen)
            gap = -1;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0)
            $display("Test %-12s ok", name);
        else
        begin
            tests_failed++;
            $display("Test %-12s %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic reset_state();
        apply_reset();
        check_value("xpos", xpos, 300);
        check_value("ypos", ypos, 70);
        check_value("move_dir", move_dir, DIR_RIGHT);
        repeat (200) advance_cycle();
        check_value("xpos", xpos, 300);
        check_value("ypos", ypos, 70);
        finish_test("reset");
    endtask

    task automatic accelerate_right();
        int gap;
        int exp_delay;
        apply_reset();
        key = KEY_RIGHT;
        wait_pos_change(0, 64, gap);
        check_value("x first step", gap, (D_MAX + 1) + (D_MAX - D_STEP + 1)); // At MAX no step.
        exp_delay = D_MAX - D_STEP;
        repeat (7)
        begin
            exp_delay = (exp_delay - D_STEP > D_MIN) ? exp_delay - D_STEP : D_MIN;
            wait_pos_change(0, 64, gap);
            check_value("x step gap", gap, exp_delay + 1);
        end
        check_value("move_dir", move_dir, DIR_RIGHT);
        check_value("ypos", ypos, 70);
        finish_test("accelerate");
    endtask

    task automatic coast_after_release();
        int gap;
        int exp_delay;
        int x_rel;
        apply_reset();
        key = KEY_RIGHT;
        repeat (8) wait_pos_change(0, 64, gap);
        key = 4'b0000;
        x_rel = xpos;
        exp_delay = D_MIN;
        while (exp_delay < D_MAX)
        begin
            wait_pos_change(0, 64, gap);
            check_value("x coast gap", gap, exp_delay + 1);
            exp_delay += D_STEP;
        end
        wait_pos_change(0, 200, gap);
        check_value("x gap after stop", gap, -1);
        check_value("xpos", xpos, x_rel + (D_MAX - D_MIN) / D_STEP);
        finish_test("coast");
    endtask

    task automatic momentum_turn();
        int gap;
        int x_turn;
        int y_turn;
        int x_max;
        apply_reset();
        key = KEY_RIGHT;
        repeat (6) wait_pos_change(0, 64, gap);
        key = KEY_UP;
        advance_cycle();
        check_value("move_dir", move_dir, DIR_UP);
        x_turn = xpos;
        y_turn = ypos;
        repeat (300) advance_cycle();
        check_value("xpos", xpos, x_turn + (D_MAX - D_MIN) / D_STEP);
        check_value("ypos decreased", ypos < y_turn, 1'b1);
        key = KEY_LEFT;
        x_max = xpos;
        repeat (200)
        begin
            advance_cycle();
            if (xpos > x_max)
                x_max = xpos;
        end
        check_value("xpos peak after LEFT", x_max, x_turn + (D_MAX - D_MIN) / D_STEP);
        finish_test("momentum");
    endtask

    task automatic wall_and_surface();
        int gap;
        int n;
        apply_reset();
        key = KEY_UP;
        n = 0;
        while ((ypos >= 27) && (n < 1500))
        begin
            advance_cycle();
            n++;
        end
        if (ypos >= 27)
            report_failure("ypos did not fall below 27 while UP was held");
        gap = 0;
        while ((ypos != 0) && (gap != -1))
        begin
            wait_pos_change(1, 64, gap);
            if ((gap != -1) && (ypos <= 16))
                check_value("y gap off track", gap, D_SLOWED + 1);
        end
        if (gap == -1)
            report_failure("ypos stopped moving before it reached 0");
        wait_pos_change(1, 100, gap);
        check_value("y gap at wall", gap, -1);
        check_value("ypos", ypos, 0);
        key = KEY_LEFT;
        n = 0;
        while ((xpos != 28) && (n < 4800))
        begin
            advance_cycle();
            n++;
        end
        wait_pos_change(0, 100, gap);
        check_value("x gap at wall", gap, -1);
        check_value("xpos", xpos, 28);
        finish_test("wall");
    endtask

    task automatic random_keys();
        int r;
        int n;
        apply_reset();
        seed = SEED;
        n = 0;
        while (n < 800)
        begin
            r = $random(seed);
            if (r[4])
                key = 4'b0001 << r[1:0];
            else
                key = r[3:0]; // Zero and multi-bit words too.
            repeat (int'(r[12:8]) + 1)
            begin
                advance_cycle();
                n++;
            end
        end
        key = 4'b0000;
        finish_test("random");
    endtask

    initial
    begin
        pclk = 1'b0;
        rst = 1'b1;
        key = 4'b0000;
        cyc = 0;
        checks = 0;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = SEED;
        reset_state();
        accelerate_right();
        coast_after_release();
        momentum_turn();
        wall_and_surface();
        random_keys();
        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        #(BUDGET_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog stopped the run after %0d cycles at test %0d", cyc, tests_run + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/axis_speed.sv
`timescale 1ns/1ps
`default_nettype none

module axis_speed #(
    parameter int DELAY_W      = 24,
    parameter int DELAY_MIN    = 160000,
    parameter int DELAY_STEP   = 2000,
    parameter int DELAY_SLOWED = 490000,
    parameter int DELAY_MAX    = 500000
) (
    input  logic pclk,
    input  logic rst,
    input  logic held,
    input  logic on_track,
    output logic step
);

    logic [DELAY_W-1:0] timer;
    logic [DELAY_W-1:0] delay;
    logic [DELAY_W-1:0] target;
    logic               expire;

    assign expire = (timer >= delay);
    assign target = on_track ? DELAY_W'(DELAY_MIN) : DELAY_W'(DELAY_SLOWED);

    // At DELAY_MAX the axis is at rest.
    assign step = expire && (delay < DELAY_W'(DELAY_MAX));

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            timer <= '0;
            delay <= DELAY_W'(DELAY_MAX);
        end
        else if (!expire)
        begin
            timer <= timer + 1'b1;
        end
        else
        begin
            timer <= '0;
            if (held)
            begin
                // Ramp toward the surface target.
                if (delay > target)
                begin
                    delay <= delay - DELAY_W'(DELAY_STEP);
                end
                else if (delay < target)
                begin
                    delay <= delay + DELAY_W'(DELAY_STEP);
                end
            end
            else if (delay < DELAY_W'(DELAY_MAX))
            begin
                delay <= delay + DELAY_W'(DELAY_STEP); // Coast down.
            end
        end
    end

    a_delay_max: assert property (
        @(posedge pclk) disable iff (rst)
        delay <= DELAY_W'(DELAY_MAX)
    );

    a_timer_bound: assert property (
        @(posedge pclk) disable iff (rst)
        {1'b0, timer} <= ({1'b0, delay} + 1'b1)
    );

endmodule

`default_nettype wire

// File: verilog/car_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module car_ctl #(
    parameter int DELAY_MIN    = 160000,
    parameter int DELAY_STEP   = 2000,
    parameter int DELAY_SLOWED = 490000,
    parameter int DELAY_MAX    = 500000,
    parameter int DELAY_W      = 24
) (
    input  logic                      pclk,
    input  logic                      rst,
    input  logic [3:0]                key,
    output logic [car_pkg::POS_W-1:0] xpos,
    output logic [car_pkg::POS_W-1:0] ypos,
    output logic [1:0]                move_dir
);

    logic x_held;
    logic y_held;
    logic x_dec;
    logic x_inc;
    logic y_dec;
    logic y_inc;
    logic on_track;
    logic x_step;
    logic y_step;

    key_decoder key_decoder_inst (
        .pclk     (pclk),
        .rst      (rst),
        .key      (key),
        .move_dir (move_dir),
        .x_held   (x_held),
        .y_held   (y_held),
        .x_dec    (x_dec),
        .x_inc    (x_inc),
        .y_dec    (y_dec),
        .y_inc    (y_inc)
    );

    axis_speed #(
        .DELAY_W      (DELAY_W),
        .DELAY_MIN    (DELAY_MIN),
        .DELAY_STEP   (DELAY_STEP),
        .DELAY_SLOWED (DELAY_SLOWED),
        .DELAY_MAX    (DELAY_MAX)
    ) x_speed (
        .pclk     (pclk),
        .rst      (rst),
        .held     (x_held),
        .on_track (on_track),
        .step     (x_step)
    );

    axis_speed #(
        .DELAY_W      (DELAY_W),
        .DELAY_MIN    (DELAY_MIN),
        .DELAY_STEP   (DELAY_STEP),
        .DELAY_SLOWED (DELAY_SLOWED),
        .DELAY_MAX    (DELAY_MAX)
    ) y_speed (
        .pclk     (pclk),
        .rst      (rst),
        .held     (y_held),
        .on_track (on_track),
        .step     (y_step)
    );

    track_surface_map track_surface_map_inst (
        .xpos     (xpos),
        .ypos     (ypos),
        .on_track (on_track)
    );

    position_tracker position_tracker_inst (
        .pclk   (pclk),
        .rst    (rst),
        .x_step (x_step),
        .y_step (y_step),
        .x_dec  (x_dec),
        .x_inc  (x_inc),
        .y_dec  (y_dec),
        .y_inc  (y_inc),
        .xpos   (xpos),
        .ypos   (ypos)
    );

endmodule

`default_nettype wire

// File: verilog/car_pkg.sv
`default_nettype none

package car_pkg;

    localparam int POS_W = 11;

    // Heading codes.
    localparam logic [1:0] DIR_DOWN  = 2'd0;
    localparam logic [1:0] DIR_RIGHT = 2'd1;
    localparam logic [1:0] DIR_UP    = 2'd2;
    localparam logic [1:0] DIR_LEFT  = 2'd3;

    // One-hot arrow keys.
    localparam logic [3:0] KEY_UP    = 4'b0001;
    localparam logic [3:0] KEY_DOWN  = 4'b0010;
    localparam logic [3:0] KEY_LEFT  = 4'b0100;
    localparam logic [3:0] KEY_RIGHT = 4'b1000;

    // Hitbox offsets from the car origin, same on both axes.
    localparam int HIT_LO = 20;
    localparam int HIT_HI = 43;

    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;
    localparam int TILE     = 16;

    // Hitbox start must stay at or above LO, hitbox end at or below HI.
    localparam int WALL_X_LO = 3 * TILE;
    localparam int WALL_X_HI = SCREEN_W - TILE;
    localparam int WALL_Y_LO = TILE;
    localparam int WALL_Y_HI = SCREEN_H - TILE;

    localparam int START_X = 300;
    localparam int START_Y = 70;

    // Track rectangles. X0/Y0 are the minimum hitbox end,
    // X1/Y1 the maximum hitbox start.
    localparam int TRACK_N = 18;

    localparam logic [POS_W-1:0] TRACK_X0 [TRACK_N] = '{
        110, 786, 625, 625, 206, 182, 208, 270, 304,
        824, 268, 262, 235, 200, 172, 141,  86,  56
    };
    localparam logic [POS_W-1:0] TRACK_Y0 [TRACK_N] = '{
         70,  85, 260, 335, 356, 372, 500, 478, 506,
        594, 666, 640, 608, 568, 535, 502, 560,  84
    };
    localparam logic [POS_W-1:0] TRACK_X1 [TRACK_N] = '{
        825, 880, 788, 702, 625, 270, 270, 304, 948,
        948, 824, 300, 268, 235, 200, 172, 141, 141
    };
    localparam logic [POS_W-1:0] TRACK_Y1 [TRACK_N] = '{
        143, 335, 335, 430, 430, 500, 555, 594, 594,
        750, 750, 675, 746, 707, 674, 642, 614, 560
    };

endpackage

`default_nettype wire

// File: verilog/key_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module key_decoder (
    input  logic       pclk,
    input  logic       rst,
    input  logic [3:0] key,
    output logic [1:0] move_dir,
    output logic       x_held,
    output logic       y_held,
    output logic       x_dec,
    output logic       x_inc,
    output logic       y_dec,
    output logic       y_inc
);
    import car_pkg::*;

    logic [1:0] prev_dir;
    logic [1:0] key_dir;
    logic       key_valid;

    // Only a clean one-hot word counts as a press.
    always_comb
    begin
        key_valid = 1'b1;
        key_dir   = move_dir;
        case (key)
            KEY_UP:    key_dir = DIR_UP;
            KEY_DOWN:  key_dir = DIR_DOWN;
            KEY_LEFT:  key_dir = DIR_LEFT;
            KEY_RIGHT: key_dir = DIR_RIGHT;
            default:   key_valid = 1'b0;
        endcase
    end

    assign x_held = (key == KEY_LEFT) || (key == KEY_RIGHT);
    assign y_held = (key == KEY_UP) || (key == KEY_DOWN);

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            move_dir <= DIR_RIGHT;
            prev_dir <= DIR_RIGHT;
        end
        else if (key_valid && (key_dir != move_dir))
        begin
            prev_dir <= move_dir; // Old heading keeps the momentum.
            move_dir <= key_dir;
        end
    end

    // Momentum: an axis follows the old heading until the opposite key.
    assign x_dec = (move_dir == DIR_LEFT) ||
                   ((prev_dir == DIR_LEFT) && (move_dir != DIR_RIGHT));
    assign x_inc = !x_dec &&
                   ((move_dir == DIR_RIGHT) ||
                    ((prev_dir == DIR_RIGHT) && (move_dir != DIR_LEFT)));
    assign y_dec = (move_dir == DIR_UP) ||
                   ((prev_dir == DIR_UP) && (move_dir != DIR_DOWN));
    assign y_inc = !y_dec &&
                   ((move_dir == DIR_DOWN) ||
                    ((prev_dir == DIR_DOWN) && (move_dir != DIR_UP)));

    a_prev_differs: assert property (
        @(posedge pclk) disable iff (rst)
        $changed(move_dir) |-> (prev_dir != move_dir)
    );

endmodule

`default_nettype wire

// File: verilog/position_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module position_tracker (
    input  logic                      pclk,
    input  logic                      rst,
    input  logic                      x_step,
    input  logic                      y_step,
    input  logic                      x_dec,
    input  logic                      x_inc,
    input  logic                      y_dec,
    input  logic                      y_inc,
    output logic [car_pkg::POS_W-1:0] xpos,
    output logic [car_pkg::POS_W-1:0] ypos
);
    import car_pkg::*;

    localparam int EXT_W = POS_W + 1;

    logic [EXT_W-1:0] x_ext;
    logic [EXT_W-1:0] y_ext;
    logic             x_lo_ok;
    logic             x_hi_ok;
    logic             y_lo_ok;
    logic             y_hi_ok;

    assign x_ext = {1'b0, xpos};
    assign y_ext = {1'b0, ypos};

    // A step back is allowed if the hitbox start stays on the wall or inside.
    // Position 0 never steps back.
    assign x_lo_ok = (xpos != '0) && ((x_ext + EXT_W'(HIT_LO)) > EXT_W'(WALL_X_LO));
    assign y_lo_ok = (ypos != '0) && ((y_ext + EXT_W'(HIT_LO)) > EXT_W'(WALL_Y_LO));

    // Same for the hitbox end going forward.
    assign x_hi_ok = (x_ext + EXT_W'(HIT_HI)) < EXT_W'(WALL_X_HI);
    assign y_hi_ok = (y_ext + EXT_W'(HIT_HI)) < EXT_W'(WALL_Y_HI);

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            xpos <= POS_W'(START_X);
            ypos <= POS_W'(START_Y);
        end
        else
        begin
            if (x_step)
            begin
                if (x_dec && x_lo_ok)
                begin
                    xpos <= xpos - 1'b1;
                end
                else if (x_inc && x_hi_ok)
                begin
                    xpos <= xpos + 1'b1;
                end
            end
            if (y_step)
            begin
                if (y_dec && y_lo_ok)
                begin
                    ypos <= ypos - 1'b1;
                end
                else if (y_inc && y_hi_ok)
                begin
                    ypos <= ypos + 1'b1;
                end
            end
        end
    end

    a_inside_walls: assert property (
        @(posedge pclk) disable iff (rst)
        ((x_ext + EXT_W'(HIT_LO)) >= EXT_W'(WALL_X_LO)) &&
        ((x_ext + EXT_W'(HIT_HI)) <= EXT_W'(WALL_X_HI)) &&
        ((y_ext + EXT_W'(HIT_LO)) >= EXT_W'(WALL_Y_LO)) &&
        ((y_ext + EXT_W'(HIT_HI)) <= EXT_W'(WALL_Y_HI))
    );

endmodule

`default_nettype wire

// File: verilog/track_surface_map.sv
`timescale 1ns/1ps
`default_nettype none

module track_surface_map (
    input  logic [car_pkg::POS_W-1:0] xpos,
    input  logic [car_pkg::POS_W-1:0] ypos,
    output logic                      on_track
);
    import car_pkg::*;

    logic [POS_W-1:0]   x_start;
    logic [POS_W-1:0]   x_end;
    logic [POS_W-1:0]   y_start;
    logic [POS_W-1:0]   y_end;
    logic [TRACK_N-1:0] hit;

    // Walls keep the hitbox well inside the coordinate range.
    assign x_start = xpos + POS_W'(HIT_LO);
    assign x_end   = xpos + POS_W'(HIT_HI);
    assign y_start = ypos + POS_W'(HIT_LO);
    assign y_end   = ypos + POS_W'(HIT_HI);

    // Overlap with any rectangle counts as track.
    always_comb
    begin
        for (int i = 0; i < TRACK_N; i++)
        begin
            hit[i] = (x_end >= TRACK_X0[i]) &&
                     (y_end >= TRACK_Y0[i]) &&
                     (x_start <= TRACK_X1[i]) &&
                     (y_start <= TRACK_Y1[i]);
        end
    end

    assign on_track = |hit;

endmodule

`default_nettype wire
